/* flist.f */
source/frame_match_pkg.sv
source/rule_regs.sv
source/field_tagger.sv
source/loop_compare.sv
source/frame_match_top.sv
dv/clk_gen.sv
dv/tb_frame_match.sv

/* Bender.yml */
package:
  name: frame_match

sources:
  - source/frame_match_pkg.sv
  - source/rule_regs.sv
  - source/field_tagger.sv
  - source/loop_compare.sv
  - source/frame_match_top.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/tb_frame_match.sv

/* dv/tb_frame_match.sv */
`timescale 1ns/1ps

module tb_frame_match;

	localparam int OFFSET_W = 6;

	typedef struct {
		logic                     en;
		logic                     order;
		logic                     wire_order;
		logic                     sgn;
		frame_match_pkg::cmp_op_e op;
		int                       offset;
		logic [31:0]              ref_val;
		logic [31:0]              field;
		int                       len;
		logic                     mid_write;
		logic                     exp;
	} entry_t;

	logic        clk;
	logic        rst_n;
	logic [3:0]  s_axil_awaddr;
	logic        s_axil_awvalid;
	logic        s_axil_awready;
	logic [31:0] s_axil_wdata;
	logic [3:0]  s_axil_wstrb;
	logic        s_axil_wvalid;
	logic        s_axil_wready;
	logic [1:0]  s_axil_bresp;
	logic        s_axil_bvalid;
	logic        s_axil_bready;
	logic [3:0]  s_axil_araddr;
	logic        s_axil_arvalid;
	logic        s_axil_arready;
	logic [31:0] s_axil_rdata;
	logic [1:0]  s_axil_rresp;
	logic        s_axil_rvalid;
	logic        s_axil_rready;
	logic [7:0]  s_axis_tdata;
	logic        s_axis_tlast;
	logic        s_axis_tvalid;
	logic [7:0]  m_axis_tdata;
	logic        m_axis_tlast;
	logic        m_axis_tvalid;
	logic        match;

	entry_t      entries[$];
	logic [31:0] lcg_state = 32'd72;
	logic        frame_exp;
	int          cycle_count = 0;
	int          cycle_limit = 2000;

	// Input beats delayed by two cycles for comparison with the output on falling edges
	logic        p_valid[0:1];
	logic [7:0]  p_data[0:1];
	logic        p_last[0:1];
	logic        p_exp[0:1];

	clk_gen clk_gen0 (
		.clk(clk),
		.rst_n(rst_n)
	);

	frame_match_top #(
		.OFFSET_W(OFFSET_W)
	) dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.s_axil_awaddr(s_axil_awaddr),
		.s_axil_awvalid(s_axil_awvalid),
		.s_axil_awready(s_axil_awready),
		.s_axil_wdata(s_axil_wdata),
		.s_axil_wstrb(s_axil_wstrb),
		.s_axil_wvalid(s_axil_wvalid),
		.s_axil_wready(s_axil_wready),
		.s_axil_bresp(s_axil_bresp),
		.s_axil_bvalid(s_axil_bvalid),
		.s_axil_bready(s_axil_bready),
		.s_axil_araddr(s_axil_araddr),
		.s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_rdata(s_axil_rdata),
		.s_axil_rresp(s_axil_rresp),
		.s_axil_rvalid(s_axil_rvalid),
		.s_axil_rready(s_axil_rready),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tvalid(s_axis_tvalid),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.match(match)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] lcg_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi[31:16], lo[31:16]};
	endfunction

	function automatic logic [31:0] byte_swap(input logic [31:0] v);
		return {v[7:0], v[15:8], v[23:16], v[31:24]};
	endfunction

	// Reference model of the compare rules on 64-bit integers
	function automatic logic match_model(input logic sgn, input frame_match_pkg::cmp_op_e op,
		input logic [31:0] value, input logic [31:0] ref_val);
		longint a;
		longint b;
		logic   r;
		a = value;
		b = ref_val;
		if (sgn && value[31]) a -= 64'sh1_0000_0000;
		if (sgn && ref_val[31]) b -= 64'sh1_0000_0000;
		case (op)
			frame_match_pkg::op_eq:  r = (value == ref_val);
			frame_match_pkg::op_gt:  r = (a > b);
			frame_match_pkg::op_lt:  r = (a < b);
			frame_match_pkg::op_ge:  r = (a >= b);
			frame_match_pkg::op_le:  r = (a <= b);
			frame_match_pkg::op_any: r = ((value & ref_val) != 32'd0);
			frame_match_pkg::op_all: r = ((~value & ref_val) == 32'd0);
			default:                 r = 1'b0;
		endcase
		return r;
	endfunction

	function automatic logic [31:0] ctrl_word(input entry_t e);
		logic [31:0] w;
		w = '0;
		w[frame_match_pkg::ctrl_enable_bit] = e.en;
		w[frame_match_pkg::ctrl_order_bit] = e.order;
		w[frame_match_pkg::ctrl_signed_bit] = e.sgn;
		w[frame_match_pkg::ctrl_op_lsb +: 3] = e.op;
		w[frame_match_pkg::ctrl_offset_lsb +: OFFSET_W] = e.offset[OFFSET_W-1:0];
		return w;
	endfunction

	task automatic add_entry(input logic en, input logic order, input logic wire_order,
		input logic sgn, input frame_match_pkg::cmp_op_e op, input int offset,
		input logic [31:0] ref_val, input logic [31:0] field, input int len,
		input logic mid_write, input logic exp);
		entry_t e;
		e = '{en, order, wire_order, sgn, op, offset, ref_val, field, len, mid_write, exp};
		entries.push_back(e);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
		logic aw_hs;
		logic w_hs;
		@(negedge clk);
		s_axil_awaddr = addr;
		s_axil_awvalid = 1'b1;
		s_axil_wdata = data;
		s_axil_wstrb = 4'hf;
		s_axil_wvalid = 1'b1;
		while (s_axil_awvalid || s_axil_wvalid) begin
			aw_hs = s_axil_awvalid && s_axil_awready;
			w_hs = s_axil_wvalid && s_axil_wready;
			@(negedge clk);
			if (aw_hs) s_axil_awvalid = 1'b0;
			if (w_hs) s_axil_wvalid = 1'b0;
		end
		while (!s_axil_bvalid) @(negedge clk);
		check_value("s_axil_bresp", 32'd0, s_axil_bresp);
		@(negedge clk);
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
		@(negedge clk);
		s_axil_araddr = addr;
		s_axil_arvalid = 1'b1;
		while (!s_axil_arready) @(negedge clk);
		@(negedge clk);
		s_axil_arvalid = 1'b0;
		while (!s_axil_rvalid) @(negedge clk);
		data = s_axil_rdata;
		check_value("s_axil_rresp", 32'd0, s_axil_rresp);
		@(negedge clk);
	endtask

	// Filler bytes come from the LCG and the field bytes go at the offset in wire order
	task automatic send_frame(input entry_t e);
		logic [31:0] r;
		logic [7:0]  b;
		int          i;
		int          k;
		for (i = 0; i < e.len; i++) begin
			r = lcg_next();
			b = r[23:16];
			k = i - e.offset;
			if (k >= 0 && k < 4) begin
				b = e.wire_order ? e.field[8*k +: 8] : e.field[8*(3-k) +: 8];
			end
			@(negedge clk);
			s_axis_tdata = b;
			s_axis_tlast = (i == e.len - 1);
			s_axis_tvalid = 1'b1;
			frame_exp = e.exp;
		end
		@(negedge clk);
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	always @(posedge clk) begin
		p_valid[1] <= p_valid[0];
		p_data[1]  <= p_data[0];
		p_last[1]  <= p_last[0];
		p_exp[1]   <= p_exp[0];
		p_valid[0] <= s_axis_tvalid;
		p_data[0]  <= s_axis_tdata;
		p_last[0]  <= s_axis_tvalid && s_axis_tlast;
		p_exp[0]   <= frame_exp;
	end

	always @(negedge clk) begin
		if (rst_n) begin
			check_value("m_axis_tvalid", p_valid[1], m_axis_tvalid);
			check_value("match", p_valid[1] && p_last[1] && p_exp[1], match);
			if (p_valid[1]) begin
				check_value("m_axis_tdata", p_data[1], m_axis_tdata);
				check_value("m_axis_tlast", p_last[1], m_axis_tlast);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("sim failed");
			$fatal(1);
		end
	end

	initial begin
		entry_t      e;
		logic [31:0] r;
		logic [31:0] fv;
		logic [31:0] rv;
		logic [31:0] rd;
		logic [31:0] last_ctrl;
		logic [31:0] last_ref;
		int          max_len;
		int          exp_count;
		s_axil_awaddr = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata = '0;
		s_axil_wstrb = '0;
		s_axil_wvalid = 1'b0;
		s_axil_bready = 1'b1;
		s_axil_araddr = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready = 1'b1;
		s_axis_tdata = '0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		frame_exp = 1'b0;
		exp_count = 0;
		max_len = 0;

		add_entry(1, 0, 0, 0, frame_match_pkg::op_eq, 0, 32'h12345678, 32'h12345678, 8, 0, 1);
		add_entry(1, 1, 1, 0, frame_match_pkg::op_eq, 3, 32'h12345678, 32'h12345678, 10, 0, 1);
		add_entry(1, 1, 0, 0, frame_match_pkg::op_eq, 2, 32'h12345678, 32'h12345678, 8, 0, 0);
		add_entry(1, 1, 0, 0, frame_match_pkg::op_eq, 2, 32'h78563412, 32'h12345678, 8, 0, 1);
		add_entry(1, 0, 0, 0, frame_match_pkg::op_gt, 1, 32'h00000001, 32'h80000000, 8, 0, 1);
		add_entry(1, 0, 0, 1, frame_match_pkg::op_gt, 1, 32'h00000001, 32'h80000000, 8, 0, 0);
		add_entry(1, 0, 0, 0, frame_match_pkg::op_lt, 1, 32'h00000000, 32'hffffffff, 8, 0, 0);
		add_entry(1, 0, 0, 1, frame_match_pkg::op_lt, 1, 32'h00000000, 32'hffffffff, 8, 0, 1);
		add_entry(1, 0, 0, 0, frame_match_pkg::op_ge, 1, 32'h7fffffff, 32'h80000000, 8, 0, 1);
		add_entry(1, 0, 0, 1, frame_match_pkg::op_ge, 1, 32'h7fffffff, 32'h80000000, 8, 0, 0);
		add_entry(1, 0, 0, 0, frame_match_pkg::op_le, 0, 32'h80000000, 32'h7fffffff, 6, 0, 1);
		add_entry(1, 0, 0, 1, frame_match_pkg::op_le, 0, 32'h80000000, 32'h7fffffff, 6, 0, 0);
		add_entry(1, 0, 0, 0, frame_match_pkg::op_any, 2, 32'h0000000f, 32'h000000f0, 8, 0, 0);
		add_entry(1, 1, 1, 0, frame_match_pkg::op_any, 2, 32'h00000010, 32'h00000011, 8, 0, 1);
		add_entry(1, 0, 0, 0, frame_match_pkg::op_all, 2, 32'h0000000f, 32'h000000ff, 8, 0, 1);
		add_entry(1, 0, 0, 0, frame_match_pkg::op_all, 2, 32'h0000000f, 32'h0000000e, 8, 0, 0);
		add_entry(1, 0, 0, 0, frame_match_pkg::op_never, 1, 32'hcafe0001, 32'hcafe0001, 8, 0, 0);
		add_entry(0, 0, 0, 0, frame_match_pkg::op_eq, 1, 32'hcafe0002, 32'hcafe0002, 8, 0, 0);
		add_entry(1, 0, 0, 0, frame_match_pkg::op_eq, 6, 32'hcafe0003, 32'hcafe0003, 8, 0, 0);
		add_entry(1, 1, 1, 0, frame_match_pkg::op_eq, 4, 32'hcafe0004, 32'hcafe0004, 8, 0, 1);
		add_entry(1, 0, 0, 0, frame_match_pkg::op_eq, 12, 32'ha5a50f0f, 32'ha5a50f0f, 20, 1, 1);

		// Random entries where some are sent in the opposite byte order to the rule
		repeat (16) begin
			r = lcg_next();
			fv = lcg_word();
			rv = r[19] ? fv : (r[18] ? (fv & lcg_word()) : lcg_word());
			e = '{1'b1, r[27], r[17] ? !r[27] : r[27], r[28],
				frame_match_pkg::cmp_op_e'(r[31:29]), r[26:24] + r[23], rv, fv,
				r[26:24] + r[23] + 4 + r[22:20], 1'b0, 1'b0};
			e.exp = match_model(e.sgn, e.op,
				(e.wire_order == e.order) ? fv : byte_swap(fv), rv);
			entries.push_back(e);
		end

		foreach (entries[n]) begin
			if (entries[n].len > max_len) max_len = entries[n].len;
		end
		cycle_limit = entries.size() * (max_len + 30) + 200;

		wait (rst_n);
		foreach (entries[n]) begin
			e = entries[n];
			last_ref = e.ref_val;
			last_ctrl = ctrl_word(e);
			axil_write(frame_match_pkg::addr_ref, last_ref);
			axil_write(frame_match_pkg::addr_ctrl, last_ctrl);
			if (e.mid_write) begin
				fork
					send_frame(e);
					begin
						repeat (3) @(negedge clk);
						axil_write(frame_match_pkg::addr_ctrl, 32'h0000_0071);
					end
				join
			end else begin
				send_frame(e);
			end
			if (e.exp) exp_count++;
		end

		axil_read(frame_match_pkg::addr_count, rd);
		check_value("count", exp_count, rd);
		axil_read(frame_match_pkg::addr_ctrl, rd);
		check_value("ctrl", last_ctrl, rd);
		axil_read(frame_match_pkg::addr_ref, rd);
		check_value("ref", last_ref, rd);

		$display("sim passed");
		$finish;
	end

endmodule

/* dv/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset is released on a falling edge after five rising edges
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* source/frame_match_top.sv */
`timescale 1ns/1ps

module frame_match_top #(
	parameter int OFFSET_W = 6
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [3:0]  s_axil_awaddr,
	input  logic        s_axil_awvalid,
	output logic        s_axil_awready,
	input  logic [31:0] s_axil_wdata,
	input  logic [3:0]  s_axil_wstrb,
	input  logic        s_axil_wvalid,
	output logic        s_axil_wready,
	output logic [1:0]  s_axil_bresp,
	output logic        s_axil_bvalid,
	input  logic        s_axil_bready,
	input  logic [3:0]  s_axil_araddr,
	input  logic        s_axil_arvalid,
	output logic        s_axil_arready,
	output logic [31:0] s_axil_rdata,
	output logic [1:0]  s_axil_rresp,
	output logic        s_axil_rvalid,
	input  logic        s_axil_rready,
	input  logic [7:0]  s_axis_tdata,
	input  logic        s_axis_tlast,
	input  logic        s_axis_tvalid,
	output logic [7:0]  m_axis_tdata,
	output logic        m_axis_tlast,
	output logic        m_axis_tvalid,
	output logic        match
);

	logic                     enable;
	logic                     order;
	logic                     is_signed;
	frame_match_pkg::cmp_op_e op;
	logic [OFFSET_W-1:0]      offset;
	logic [31:0]              ref_value;

	logic [7:0]               t_data;
	logic                     t_last;
	logic                     t_valid;
	logic                     field_byte;
	logic                     field_last;
	logic [7:0]               ref_byte;
	logic                     frame_enable;
	logic                     frame_order;
	logic                     frame_signed;
	frame_match_pkg::cmp_op_e frame_op;

	rule_regs #(
		.OFFSET_W(OFFSET_W)
	) regs0 (
		.clk(clk),
		.rst_n(rst_n),
		.s_axil_awaddr(s_axil_awaddr),
		.s_axil_awvalid(s_axil_awvalid),
		.s_axil_awready(s_axil_awready),
		.s_axil_wdata(s_axil_wdata),
		.s_axil_wstrb(s_axil_wstrb),
		.s_axil_wvalid(s_axil_wvalid),
		.s_axil_wready(s_axil_wready),
		.s_axil_bresp(s_axil_bresp),
		.s_axil_bvalid(s_axil_bvalid),
		.s_axil_bready(s_axil_bready),
		.s_axil_araddr(s_axil_araddr),
		.s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_rdata(s_axil_rdata),
		.s_axil_rresp(s_axil_rresp),
		.s_axil_rvalid(s_axil_rvalid),
		.s_axil_rready(s_axil_rready),
		.match_event(match),
		.enable(enable),
		.order(order),
		.is_signed(is_signed),
		.op(op),
		.offset(offset),
		.ref_value(ref_value)
	);

	field_tagger #(
		.OFFSET_W(OFFSET_W)
	) tagger0 (
		.clk(clk),
		.rst_n(rst_n),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tvalid(s_axis_tvalid),
		.enable(enable),
		.order(order),
		.is_signed(is_signed),
		.op(op),
		.offset(offset),
		.ref_value(ref_value),
		.t_data(t_data),
		.t_last(t_last),
		.t_valid(t_valid),
		.field_byte(field_byte),
		.field_last(field_last),
		.ref_byte(ref_byte),
		.frame_enable(frame_enable),
		.frame_order(frame_order),
		.frame_signed(frame_signed),
		.frame_op(frame_op)
	);

	loop_compare compare0 (
		.clk(clk),
		.rst_n(rst_n),
		.t_data(t_data),
		.t_last(t_last),
		.t_valid(t_valid),
		.field_byte(field_byte),
		.field_last(field_last),
		.ref_byte(ref_byte),
		.frame_enable(frame_enable),
		.frame_order(frame_order),
		.frame_signed(frame_signed),
		.frame_op(frame_op),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.match(match)
	);

endmodule

/* source/loop_compare.sv */
`timescale 1ns/1ps

module loop_compare (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [7:0]                 t_data,
	input  logic                       t_last,
	input  logic                       t_valid,
	input  logic                       field_byte,
	input  logic                       field_last,
	input  logic [7:0]                 ref_byte,
	input  logic                       frame_enable,
	input  logic                       frame_order,
	input  logic                       frame_signed,
	input  frame_match_pkg::cmp_op_e   frame_op,
	output logic [7:0]                 m_axis_tdata,
	output logic                       m_axis_tlast,
	output logic                       m_axis_tvalid,
	output logic                       match
);

	logic [31:0] field_acc;
	logic [31:0] ref_acc;
	logic [31:0] field_nxt;
	logic [31:0] ref_nxt;
	logic        cmp_now;
	logic        result_q;
	logic        seen_q;
	logic        hit;

	function automatic logic compare(input frame_match_pkg::cmp_op_e cop, input logic sgn,
		input logic [31:0] a, input logic [31:0] b);
		logic gt;
		logic lt;
		if (sgn) begin
			gt = $signed(a) > $signed(b);
			lt = $signed(a) < $signed(b);
		end else begin
			gt = a > b;
			lt = a < b;
		end
		case (cop)
			frame_match_pkg::op_eq:  return a == b;
			frame_match_pkg::op_gt:  return gt;
			frame_match_pkg::op_lt:  return lt;
			frame_match_pkg::op_ge:  return !lt;
			frame_match_pkg::op_le:  return !gt;
			frame_match_pkg::op_any: return |(a & b);
			frame_match_pkg::op_all: return (a & b) == b;
			default:                 return 1'b0;
		endcase
	endfunction

	// Little-endian bytes enter at the top so both orders end up in natural order
	always_comb begin
		if (frame_order) begin
			field_nxt = {t_data, field_acc[31:8]};
			ref_nxt   = {ref_byte, ref_acc[31:8]};
		end else begin
			field_nxt = {field_acc[23:0], t_data};
			ref_nxt   = {ref_acc[23:0], ref_byte};
		end
	end

	assign cmp_now = compare(frame_op, frame_signed, field_nxt, ref_nxt);

	// A field that ends on the tlast beat uses the fresh result
	assign hit = field_last ? cmp_now : (seen_q && result_q);

	always_ff @(posedge clk) begin
		if (t_valid && field_byte) begin
			field_acc <= field_nxt;
			ref_acc   <= ref_nxt;
		end
		m_axis_tdata <= t_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			seen_q        <= 1'b0;
			result_q      <= 1'b0;
			m_axis_tvalid <= 1'b0;
			m_axis_tlast  <= 1'b0;
			match         <= 1'b0;
		end else begin
			m_axis_tvalid <= t_valid;
			m_axis_tlast  <= t_valid && t_last;
			match         <= t_valid && t_last && frame_enable && hit;
			if (t_valid && t_last) begin
				seen_q <= 1'b0;
			end else if (field_last) begin
				seen_q   <= 1'b1;
				result_q <= cmp_now;
			end
		end
	end

endmodule

/* source/field_tagger.sv */
`timescale 1ns/1ps

module field_tagger #(
	parameter int OFFSET_W = 6
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [7:0]                 s_axis_tdata,
	input  logic                       s_axis_tlast,
	input  logic                       s_axis_tvalid,
	input  logic                       enable,
	input  logic                       order,
	input  logic                       is_signed,
	input  frame_match_pkg::cmp_op_e   op,
	input  logic [OFFSET_W-1:0]        offset,
	input  logic [31:0]                ref_value,
	output logic [7:0]                 t_data,
	output logic                       t_last,
	output logic                       t_valid,
	output logic                       field_byte,
	output logic                       field_last,
	output logic [7:0]                 ref_byte,
	output logic                       frame_enable,
	output logic                       frame_order,
	output logic                       frame_signed,
	output frame_match_pkg::cmp_op_e   frame_op
);

	// One spare bit so a saturated position lies beyond any field
	localparam int POS_W = OFFSET_W + 1;

	logic [POS_W-1:0]    pos_q;
	logic                first_beat;
	logic [OFFSET_W-1:0] offset_q;
	logic [31:0]         ref_q;
	logic [OFFSET_W-1:0] cur_offset;
	logic [31:0]         cur_ref;
	logic                cur_order;
	logic [POS_W-1:0]    rel;
	logic                in_field;
	logic [1:0]          ref_sel;

	// The first beat uses the live rule since the field may start at byte 0
	assign first_beat = (pos_q == '0);
	assign cur_offset = first_beat ? offset : offset_q;
	assign cur_ref    = first_beat ? ref_value : ref_q;
	assign cur_order  = first_beat ? order : frame_order;

	assign rel      = pos_q - POS_W'(cur_offset);
	assign in_field = (pos_q >= POS_W'(cur_offset)) && (rel < POS_W'(4));
	assign ref_sel  = cur_order ? rel[1:0] : 2'd3 - rel[1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos_q        <= '0;
			frame_enable <= 1'b0;
			frame_order  <= 1'b0;
			frame_signed <= 1'b0;
			frame_op     <= frame_match_pkg::op_eq;
		end else if (s_axis_tvalid) begin
			if (first_beat) begin
				frame_enable <= enable;
				frame_order  <= order;
				frame_signed <= is_signed;
				frame_op     <= op;
			end
			if (s_axis_tlast) begin
				pos_q <= '0;
			end else if (pos_q != '1) begin
				pos_q <= pos_q + POS_W'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (s_axis_tvalid && first_beat) begin
			offset_q <= offset;
			ref_q    <= ref_value;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			t_valid    <= 1'b0;
			t_last     <= 1'b0;
			field_byte <= 1'b0;
			field_last <= 1'b0;
		end else begin
			t_valid    <= s_axis_tvalid;
			t_last     <= s_axis_tvalid && s_axis_tlast;
			field_byte <= s_axis_tvalid && in_field;
			field_last <= s_axis_tvalid && in_field && (rel[1:0] == 2'd3);
		end
	end

	always_ff @(posedge clk) begin
		t_data   <= s_axis_tdata;
		ref_byte <= cur_ref[8*ref_sel +: 8];
	end

endmodule

/* source/rule_regs.sv */
`timescale 1ns/1ps

module rule_regs #(
	parameter int OFFSET_W = 6
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [3:0]                 s_axil_awaddr,
	input  logic                       s_axil_awvalid,
	output logic                       s_axil_awready,
	input  logic [31:0]                s_axil_wdata,
	input  logic [3:0]                 s_axil_wstrb,
	input  logic                       s_axil_wvalid,
	output logic                       s_axil_wready,
	output logic [1:0]                 s_axil_bresp,
	output logic                       s_axil_bvalid,
	input  logic                       s_axil_bready,
	input  logic [3:0]                 s_axil_araddr,
	input  logic                       s_axil_arvalid,
	output logic                       s_axil_arready,
	output logic [31:0]                s_axil_rdata,
	output logic [1:0]                 s_axil_rresp,
	output logic                       s_axil_rvalid,
	input  logic                       s_axil_rready,
	input  logic                       match_event,
	output logic                       enable,
	output logic                       order,
	output logic                       is_signed,
	output frame_match_pkg::cmp_op_e   op,
	output logic [OFFSET_W-1:0]        offset,
	output logic [31:0]                ref_value
);

	logic [31:0] ctrl_q;
	logic [31:0] ref_q;
	logic [31:0] count_q;
	logic [3:0]  aw_addr_q;
	logic        aw_held;
	logic [31:0] w_data_q;
	logic [3:0]  w_strb_q;
	logic        w_held;
	logic        commit;

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] word;
		word = old_word;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				word[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return word;
	endfunction

	// A write completes once both address and data have been taken
	assign commit = aw_held && w_held && !s_axil_bvalid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s_axil_awready <= 1'b0;
			s_axil_wready  <= 1'b0;
			aw_held        <= 1'b0;
			w_held         <= 1'b0;
		end else begin
			s_axil_awready <= s_axil_awvalid && !s_axil_awready && !aw_held && !s_axil_bvalid;
			s_axil_wready  <= s_axil_wvalid && !s_axil_wready && !w_held && !s_axil_bvalid;
			if (s_axil_awvalid && s_axil_awready) begin
				aw_held <= 1'b1;
			end else if (commit) begin
				aw_held <= 1'b0;
			end
			if (s_axil_wvalid && s_axil_wready) begin
				w_held <= 1'b1;
			end else if (commit) begin
				w_held <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (s_axil_awvalid && s_axil_awready) begin
			aw_addr_q <= s_axil_awaddr;
		end
		if (s_axil_wvalid && s_axil_wready) begin
			w_data_q <= s_axil_wdata;
			w_strb_q <= s_axil_wstrb;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctrl_q        <= '0;
			ref_q         <= '0;
			count_q       <= '0;
			s_axil_bvalid <= 1'b0;
		end else begin
			if (commit) begin
				case (aw_addr_q)
					frame_match_pkg::addr_ctrl: ctrl_q <= merge_bytes(ctrl_q, w_data_q, w_strb_q);
					frame_match_pkg::addr_ref:  ref_q <= merge_bytes(ref_q, w_data_q, w_strb_q);
					default: ;
				endcase
				s_axil_bvalid <= 1'b1;
			end else if (s_axil_bvalid && s_axil_bready) begin
				s_axil_bvalid <= 1'b0;
			end
			if (match_event) begin
				count_q <= count_q + 32'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s_axil_arready <= 1'b0;
			s_axil_rvalid  <= 1'b0;
		end else begin
			s_axil_arready <= s_axil_arvalid && !s_axil_arready && !s_axil_rvalid;
			if (s_axil_arvalid && s_axil_arready) begin
				s_axil_rvalid <= 1'b1;
			end else if (s_axil_rvalid && s_axil_rready) begin
				s_axil_rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (s_axil_arvalid && s_axil_arready) begin
			case (s_axil_araddr)
				frame_match_pkg::addr_ctrl:  s_axil_rdata <= ctrl_q;
				frame_match_pkg::addr_ref:   s_axil_rdata <= ref_q;
				frame_match_pkg::addr_count: s_axil_rdata <= count_q;
				default:                     s_axil_rdata <= '0;
			endcase
		end
	end

	assign s_axil_bresp = 2'b00;
	assign s_axil_rresp = 2'b00;

	assign enable    = ctrl_q[frame_match_pkg::ctrl_enable_bit];
	assign order     = ctrl_q[frame_match_pkg::ctrl_order_bit];
	assign is_signed = ctrl_q[frame_match_pkg::ctrl_signed_bit];
	assign op        = frame_match_pkg::cmp_op_e'(ctrl_q[frame_match_pkg::ctrl_op_lsb +: 3]);
	assign offset    = ctrl_q[frame_match_pkg::ctrl_offset_lsb +: OFFSET_W];
	assign ref_value = ref_q;

endmodule

/* source/frame_match_pkg.sv */
package frame_match_pkg;

	// Compare opcodes applied to the assembled 32-bit field
	// Signedness only affects the ordering compares gt, lt, ge and le
	typedef enum logic [2:0] {
		op_eq    = 3'd0,
		op_gt    = 3'd1,
		op_lt    = 3'd2,
		op_ge    = 3'd3,
		op_le    = 3'd4,
		// Field AND reference is nonzero
		op_any   = 3'd5,
		// Every reference bit is also set in the field
		op_all   = 3'd6,
		op_never = 3'd7
	} cmp_op_e;

	// Byte addresses of the register block
	localparam logic [3:0] addr_ctrl  = 4'h0;
	localparam logic [3:0] addr_ref   = 4'h4;
	localparam logic [3:0] addr_count = 4'h8;

	// Control word layout
	localparam int ctrl_enable_bit = 0;

	// Set means little-endian with the least significant byte first
	localparam int ctrl_order_bit  = 1;
	localparam int ctrl_signed_bit = 2;

	// Opcode occupies bits 6:4
	localparam int ctrl_op_lsb     = 4;

	// Field offset in bytes whose width is set by the OFFSET_W parameter
	localparam int ctrl_offset_lsb = 16;

endpackage
